//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

   ////////////////////
   // widths and types

   localparam int CODE_AW = 10;     // code address bits

   typedef logic [7:0]         byte_t;
   typedef logic [CODE_AW-1:0] pc_t;
   typedef logic [2:0]         rn_t;

   ////////////////////
   // fixed addresses

   localparam byte_t       DIR_B      = 8'hF0;  // direct address of B
   localparam logic [15:0] XADDR_STAT = 16'h0200;  // movx read, uart busy in bit 0
   localparam logic [15:0] XADDR_TX   = 16'h0201;  // movx write, sends a byte

   ////////////////////
   // timing

   localparam int BAUD_DIV        = 104;  // clocks per bit, minus one
   localparam int UART_FRAME_BITS = 10;
   localparam int DIV_STEPS       = 8;    // one quotient bit per step

   // register forms carry rn in the low three bits, stored here as zero
   typedef enum logic [7:0] {
      LJMP   = 8'h02,
      INCA   = 8'h04,
      INCR   = 8'h08,
      DECA   = 8'h14,
      DECR   = 8'h18,
      ADDAI  = 8'h24,
      ADDAR  = 8'h28,
      ADDCI  = 8'h34,
      JC     = 8'h40,
      ORLA   = 8'h44,  // orl a, #imm
      JNC    = 8'h50,
      ANLAI  = 8'h54,
      JZ     = 8'h60,
      XRLA   = 8'h64,  // xrl a, #imm
      JNZ    = 8'h70,
      MOVAI  = 8'h74,
      MOVDI  = 8'h75,  // mov direct, #imm
      MOVRI  = 8'h78,
      SJMP   = 8'h80,
      DIV    = 8'h84,
      MOVDP  = 8'h90,  // mov dptr, #imm16
      SUBBAI = 8'h94,
      SUBBAR = 8'h98,
      MUL    = 8'hA4,
      CLRC   = 8'hC3,
      SETBC  = 8'hD3,
      DJNZR  = 8'hD8,
      MOVXAD = 8'hE0,  // movx a, @dptr
      CLRA   = 8'hE4,
      MOVAD  = 8'hE5,  // mov a, direct
      MOVAR  = 8'hE8,
      MOVXDA = 8'hF0,  // movx @dptr, a
      CPLA   = 8'hF4,
      MOVRA  = 8'hF8
   } opcode_e;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DEC0,   // opcode byte on the code bus
      ST_DEC1,
      ST_DEC2,
      ST_EXEC
   } state_e;

endpackage

`default_nettype wire

//--- hw/dec_exe_if.sv
`default_nettype none

interface dec_exe_if;
   import core_pkg::*;

   // decoded instruction, from decode
   opcode_e op;
   rn_t     rn;
   byte_t   imm_h;     // first operand byte
   byte_t   imm_l;     // second operand byte
   logic    exec;

   // status, from execute
   logic    done;
   logic    taken;     // branch condition holds
   logic    tx_start;  // uart send strobe

   modport dec (output op, rn, imm_h, imm_l, exec,
                input  done, taken);

   modport exe (input  op, rn, imm_h, imm_l, exec,
                output done, taken, tx_start);

endinterface

`default_nettype wire

//--- hw/core_decode.sv
`default_nettype none

module core_decode (
   input  wire                   i_clk,
   input  wire                   i_nrst,
   output core_pkg::pc_t         o_code_addr,
   input  wire core_pkg::byte_t  i_code_data,
   dec_exe_if.dec                dx
);
   import core_pkg::*;

   state_e     state;
   state_e     state_next;
   pc_t        pc;
   pc_t        pc_next;
   pc_t        rel_target;
   opcode_e    op_code;     // opcode seen on the code bus in ST_DEC0
   logic [1:0] nops_code;
   logic [1:0] nops;        // operand count of the latched opcode
   logic       pc_inc;

   // operand bytes that follow each opcode
   function automatic logic [1:0] operand_count(opcode_e opc);
      case (opc)
         LJMP, MOVDP, MOVDI: return 2'd2;
         ADDAI, ADDCI, SUBBAI, ANLAI, ORLA, XRLA, MOVAI, MOVRI,
         SJMP, JZ, JNZ, JC, JNC, DJNZR, MOVAD: return 2'd1;
         default: return 2'd0;
      endcase
   endfunction

   // register forms fold to their base value
   function automatic opcode_e normalize(byte_t code);
      opcode_e base;
      base = opcode_e'({code[7:3], 3'b000});
      case (base)
         INCR, DECR, ADDAR, SUBBAR, MOVRI, DJNZR, MOVAR, MOVRA: return base;
         default: return opcode_e'(code);
      endcase
   endfunction

   assign op_code   = normalize(i_code_data);
   assign nops_code = operand_count(op_code);
   assign nops      = operand_count(dx.op);

   ////////////////////
   // state machine

   always_comb begin
      state_next = state;
      case (state)
         ST_FETCH: state_next = ST_DEC0;
         ST_DEC0:  state_next = (nops_code != 2'd0) ? ST_DEC1 : ST_EXEC;
         ST_DEC1:  state_next = (nops == 2'd2) ? ST_DEC2 : ST_EXEC;
         ST_DEC2:  state_next = ST_EXEC;
         ST_EXEC: begin
            if (dx.done) state_next = ST_FETCH;  // mul/div hold here
         end
         default:  state_next = ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ST_FETCH;
      end else begin
         state <= state_next;
      end
   end

   assign dx.exec = (state == ST_EXEC);

   // instruction latches
   always_ff @(posedge i_clk) begin
      if (state == ST_DEC0) begin
         dx.op <= op_code;
         dx.rn <= i_code_data[2:0];
      end
      if (state == ST_DEC1) begin
         dx.imm_h <= i_code_data;
      end
      if (state == ST_DEC2) begin
         dx.imm_l <= i_code_data;
      end
   end

   ////////////////////
   // program counter

   // one increment per fetched byte
   assign pc_inc = (state == ST_FETCH) ||
                   ((state == ST_DEC0) && (nops_code != 2'd0)) ||
                   ((state == ST_DEC1) && (nops == 2'd2));

   // relative offset is always the first operand
   assign rel_target = pc + pc_t'({{(CODE_AW-8){dx.imm_h[7]}}, dx.imm_h});

   always_comb begin
      pc_next = pc;
      if (pc_inc) begin
         pc_next = pc + pc_t'(1);
      end else if (dx.exec && dx.done) begin
         if (dx.op == LJMP) begin
            pc_next = {dx.imm_h[CODE_AW-9:0], dx.imm_l};
         end else if ((dx.op == SJMP) || dx.taken) begin
            pc_next = rel_target;
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         pc <= '0;
      end else begin
         pc <= pc_next;
      end
   end

   assign o_code_addr = pc;  // sync read, data next cycle

   // longest case is mul with a = 255
   a_exec_bounded: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(dx.exec) |-> ##[1:2 + DIV_STEPS + 255] !dx.exec);

endmodule

`default_nettype wire

//--- hw/core_execute.sv
`default_nettype none

module core_execute (
   input  wire                   i_clk,
   input  wire                   i_nrst,
   dec_exe_if.exe                dx,
   output core_pkg::rn_t         o_reg_addr,
   output logic                  o_reg_wr,
   output core_pkg::byte_t       o_reg_wdata,
   input  wire core_pkg::byte_t  i_reg_rdata,
   output core_pkg::byte_t       o_tx_byte,
   input  wire                   i_tx_busy
);
   import core_pkg::*;

   typedef logic [$clog2(DIV_STEPS+1)-1:0] step_t;

   byte_t       acc;
   byte_t       b;
   logic        carry;
   logic [15:0] dptr;
   byte_t       acc_next;
   byte_t       b_next;
   logic        carry_next;
   logic        acc_zero;
   byte_t       add_b;
   logic        add_cin;
   logic [8:0]  add_sum;
   byte_t       sub_b;
   logic        sub_bin;
   logic [8:0]  sub_diff;   // bit 8 is the borrow
   byte_t       reg_dec;
   logic        seq_busy;
   step_t       step_cnt;
   logic [15:0] prod;       // mul product, or div remainder:quotient
   logic        is_seq;
   logic        seq_first;
   logic        seq_last;
   logic        mul_step;
   logic        div_step;
   logic [8:0]  div_shift;
   logic [8:0]  div_diff;
   logic        div_ge;
   byte_t       div_rem;

   assign acc_zero = (acc == 8'h00);

   ////////////////////
   // alu

   assign add_b   = (dx.op == ADDAR) ? i_reg_rdata :
                    ((dx.op == ADDAI) || (dx.op == ADDCI)) ? dx.imm_h : 8'h01;  // inca
   assign add_cin = carry && (dx.op == ADDCI);
   assign add_sum = {1'b0, acc} + {1'b0, add_b} + {8'h00, add_cin};

   // deca and the mul count-down take a - 0 - 1
   assign sub_b    = (dx.op == SUBBAR) ? i_reg_rdata :
                     (dx.op == SUBBAI) ? dx.imm_h : 8'h00;
   assign sub_bin  = ((dx.op == SUBBAI) || (dx.op == SUBBAR)) ? carry : 1'b1;
   assign sub_diff = {1'b0, acc} - {1'b0, sub_b} - {8'h00, sub_bin};

   always_comb begin
      case (dx.op)
         INCA, ADDAI, ADDCI, ADDAR: acc_next = add_sum[7:0];
         DECA, SUBBAI, SUBBAR:      acc_next = sub_diff[7:0];
         ANLAI:  acc_next = acc & dx.imm_h;
         ORLA:   acc_next = acc | dx.imm_h;
         XRLA:   acc_next = acc ^ dx.imm_h;
         CLRA:   acc_next = 8'h00;
         CPLA:   acc_next = ~acc;
         MOVAI:  acc_next = dx.imm_h;
         MOVAR:  acc_next = i_reg_rdata;
         MOVAD:  acc_next = (dx.imm_h == DIR_B) ? b : acc;
         MOVXAD: acc_next = (dptr == XADDR_STAT) ? {7'h00, i_tx_busy} : acc;
         MUL, DIV: acc_next = prod[7:0];
         default: acc_next = acc;
      endcase
   end

   always_comb begin
      case (dx.op)
         MOVDI:    b_next = (dx.imm_h == DIR_B) ? dx.imm_l : b;
         MUL, DIV: b_next = prod[15:8];
         default:  b_next = b;
      endcase
   end

   always_comb begin
      case (dx.op)
         CLRC:                 carry_next = 1'b0;
         SETBC:                carry_next = 1'b1;
         ADDAI, ADDCI, ADDAR:  carry_next = add_sum[8];
         SUBBAI, SUBBAR:       carry_next = sub_diff[8];
         MUL, DIV:             carry_next = 1'b0;
         default:              carry_next = carry;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= 8'h00;
         b     <= 8'h00;
         carry <= 1'b0;
         dptr  <= 16'h0000;
      end else if (dx.exec) begin
         if (mul_step) acc <= sub_diff[7:0];  // a doubles as the mul counter
         if (dx.done) begin
            acc   <= acc_next;
            b     <= b_next;
            carry <= carry_next;
            if (dx.op == MOVDP) dptr <= {dx.imm_h, dx.imm_l};
         end
      end
   end

   ////////////////////
   // mul/div sequencer

   assign is_seq    = (dx.op == MUL) || (dx.op == DIV);
   assign seq_first = dx.exec && is_seq && !seq_busy;
   assign mul_step  = dx.exec && seq_busy && (dx.op == MUL) && !acc_zero;
   assign div_step  = dx.exec && seq_busy && (dx.op == DIV) && (step_cnt != '0);
   assign seq_last  = dx.exec && seq_busy &&
                      ((dx.op == MUL) ? acc_zero : (step_cnt == '0));

   // restoring divide, one bit per step
   assign div_shift = {prod[15:8], prod[7]};
   assign div_diff  = div_shift - {1'b0, b};
   assign div_ge    = (div_shift >= {1'b0, b});
   assign div_rem   = div_ge ? div_diff[7:0] : div_shift[7:0];

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         seq_busy <= 1'b0;
         step_cnt <= '0;
      end else begin
         if (seq_first) seq_busy <= 1'b1;
         else if (seq_last) seq_busy <= 1'b0;
         if (seq_first) step_cnt <= step_t'(DIV_STEPS);
         else if (div_step) step_cnt <= step_cnt - step_t'(1);
      end
   end

   always_ff @(posedge i_clk) begin
      if (seq_first) prod <= (dx.op == DIV) ? {8'h00, acc} : 16'h0000;
      else if (mul_step) prod <= prod + {8'h00, b};
      else if (div_step) prod <= {div_rem, prod[6:0], div_ge};
   end

   assign dx.done = dx.exec && (is_seq ? seq_last : 1'b1);

   ////////////////////
   // branches, registers, uart

   assign reg_dec = i_reg_rdata - 8'h01;

   always_comb begin
      case (dx.op)
         JZ:      dx.taken = acc_zero;
         JNZ:     dx.taken = !acc_zero;
         JC:      dx.taken = carry;
         JNC:     dx.taken = !carry;
         DJNZR:   dx.taken = (reg_dec != 8'h00);
         default: dx.taken = 1'b0;
      endcase
   end

   assign o_reg_addr = dx.rn;
   assign o_reg_wr   = dx.exec && ((dx.op == MOVRA) || (dx.op == MOVRI) ||
                       (dx.op == INCR) || (dx.op == DECR) || (dx.op == DJNZR));

   always_comb begin
      case (dx.op)
         MOVRA:   o_reg_wdata = acc;
         MOVRI:   o_reg_wdata = dx.imm_h;
         INCR:    o_reg_wdata = i_reg_rdata + 8'h01;
         default: o_reg_wdata = reg_dec;  // decr, djnz
      endcase
   end

   assign dx.tx_start = dx.exec && (dx.op == MOVXDA) && (dptr == XADDR_TX);
   assign o_tx_byte   = acc;

   // one write per instruction, then decode leaves exec
   a_reg_wr_once: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_reg_wr |-> dx.exec ##1 !dx.exec);

   // software polls, so a send always finds the transmitter free
   a_tx_free: assert property (@(posedge i_clk) disable iff (!i_nrst)
      dx.tx_start |-> !i_tx_busy ##1 i_tx_busy);

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`default_nettype none

module uart_tx (
   input  wire                   i_clk,
   input  wire                   i_nrst,
   input  wire                   i_start,
   input  wire core_pkg::byte_t  i_data,
   output logic                  o_busy,
   output logic                  o_uart_tx
);
   import core_pkg::*;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;
   typedef logic [$clog2(BAUD_DIV+1)-1:0]    baud_cnt_t;
   typedef logic [$clog2(UART_FRAME_BITS)-1:0] bit_cnt_t;

   tx_state_e state;
   baud_cnt_t baud_cnt;
   bit_cnt_t  bit_cnt;   // 0 is the start bit, last is the stop bit
   byte_t     shreg;
   logic      bit_end;
   logic      frame_end;

   assign bit_end   = (state != TX_IDLE) && (baud_cnt == baud_cnt_t'(BAUD_DIV));
   assign frame_end = bit_end && (bit_cnt == bit_cnt_t'(UART_FRAME_BITS - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         case (state)
            TX_IDLE:  if (i_start) state <= TX_START;  // start while busy is dropped
            TX_START: if (bit_end) state <= TX_SEND;
            TX_SEND:  if (frame_end) state <= TX_IDLE;
            default:  state <= TX_IDLE;
         endcase
         baud_cnt <= ((state == TX_IDLE) || bit_end) ? '0 : baud_cnt + baud_cnt_t'(1);
         if ((state == TX_IDLE) || frame_end) bit_cnt <= '0;
         else if (bit_end) bit_cnt <= bit_cnt + bit_cnt_t'(1);
      end
   end

   // lsb first, ones shift in behind to form the stop bit
   always_ff @(posedge i_clk) begin
      if ((state == TX_IDLE) && i_start) shreg <= i_data;
      else if ((state == TX_SEND) && bit_end) shreg <= {1'b1, shreg[7:1]};
   end

   assign o_busy    = (state != TX_IDLE);
   assign o_uart_tx = (state == TX_IDLE)  ? 1'b1 :
                      (state == TX_START) ? 1'b0 : shreg[0];

   // idle line is high, and the bit before idle was the stop bit
   a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !o_busy |-> o_uart_tx && (!$past(o_busy) || $past(o_uart_tx)));

endmodule

`default_nettype wire

//--- hw/core_top.sv
`default_nettype none

module core_top (
   input  wire                   i_clk,
   input  wire                   i_nrst,
   output wire core_pkg::pc_t    o_code_addr,
   input  wire core_pkg::byte_t  i_code_data,
   output wire core_pkg::rn_t    o_reg_addr,
   output wire                   o_reg_wr,
   output wire core_pkg::byte_t  o_reg_wdata,
   input  wire core_pkg::byte_t  i_reg_rdata,
   output wire                   o_uart_tx
);
   import core_pkg::*;

   byte_t tx_byte;   // accumulator to the transmitter
   logic  tx_busy;

   dec_exe_if dx ();

   core_decode u_decode (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .o_code_addr (o_code_addr),
      .i_code_data (i_code_data),
      .dx          (dx.dec)
   );

   core_execute u_execute (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .dx          (dx.exe),
      .o_reg_addr  (o_reg_addr),
      .o_reg_wr    (o_reg_wr),
      .o_reg_wdata (o_reg_wdata),
      .i_reg_rdata (i_reg_rdata),
      .o_tx_byte   (tx_byte),
      .i_tx_busy   (tx_busy)
   );

   uart_tx u_uart_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_start   (dx.tx_start),
      .i_data    (tx_byte),
      .o_busy    (tx_busy),
      .o_uart_tx (o_uart_tx)
   );

endmodule

`default_nettype wire

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////
// reference model

// returns {expected acc, expected reg}; mul and div put the B byte in the low half
function automatic logic [15:0] ref_result(opcode_e op, byte_t acc, byte_t opnd,
                                           byte_t rval, byte_t b, logic cy);
   byte_t       a;
   byte_t       r;
   logic [15:0] p;
   a = acc;
   r = rval;
   case (op)
      INCA:   a = acc + 8'd1;
      DECA:   a = acc - 8'd1;
      ADDAI:  a = acc + opnd;
      ADDAR:  a = acc + rval;
      ADDCI:  a = acc + opnd + {7'd0, cy};
      SUBBAI: a = acc - opnd - {7'd0, cy};
      SUBBAR: a = acc - rval - {7'd0, cy};
      ANLAI:  a = acc & opnd;
      ORLA:   a = acc | opnd;
      XRLA:   a = acc ^ opnd;
      CLRA:   a = 8'd0;
      CPLA:   a = ~acc;
      MOVAI:  a = opnd;
      MOVAR:  a = rval;
      MOVRA:  r = acc;
      MOVRI:  r = opnd;
      INCR:   r = rval + 8'd1;
      DECR:   r = rval - 8'd1;
      MUL: begin
         p = acc * b;
         a = p[7:0];
         r = p[15:8];
      end
      DIV: begin
         a = acc / b;
         r = acc % b;
      end
      default: a = acc;
   endcase
   return {a, r};
endfunction

function automatic logic branch_taken(opcode_e op, byte_t acc, logic cy);
   case (op)
      JZ:      return acc == 8'd0;
      JNZ:     return acc != 8'd0;
      JC:      return cy;
      default: return !cy;  // jnc
   endcase
endfunction

// register forms carry rn in the low bits
function automatic byte_t op_rn(opcode_e op, rn_t rn);
   return {op[7:3], rn};
endfunction

function automatic logic has_imm(opcode_e op);
   return (op == ADDAI) || (op == ADDCI) || (op == SUBBAI) || (op == ANLAI) ||
          (op == ORLA) || (op == XRLA) || (op == MOVAI);
endfunction

////////////////////
// checks

task automatic fail_stop(input string why);
   $display("%s at %0t", why, $time);
   $display("Test failures found");
   $fatal(1);
endtask

task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
   if (got !== exp) begin
      $display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1);
   end
endtask

task automatic compare_reg(input rn_t got_rn, input rn_t exp_rn,
                           input byte_t got, input byte_t exp);
   if (got_rn !== exp_rn) begin
      $display("[FAIL] %0t o_reg_addr got %0d expected %0d", $time, got_rn, exp_rn);
      $display("Test failures found");
      $fatal(1);
   end
   compare_byte("o_reg_wdata", got, exp);
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1);
   end
endtask

`endif

//--- bench/tb_core.sv
`default_nettype none

module tb_core;
   import core_pkg::*;

   localparam int RUN_LIMIT = 200000;  // clocks per program
   localparam int RX_LIMIT  = 20000;   // idle clocks while a byte is due

   logic    i_clk;
   logic    i_nrst;
   byte_t   code_rdata;
   byte_t   reg_rdata;
   pc_t     code_addr;
   pc_t     addr_q;
   rn_t     reg_addr;
   logic    reg_wr;
   byte_t   reg_wdata;
   logic    uart_line;

   byte_t   code_mem [0:(1<<CODE_AW)-1];
   byte_t   regs [0:7];
   int      wp;                // assembly pointer
   byte_t   rx_q[$];
   byte_t   exp_byte_q[$];
   rn_t     exp_rn_q[$];
   byte_t   exp_val_q[$];
   logic    wr_pend;
   rn_t     wr_rn;
   byte_t   wr_val;
   opcode_e alu_ops [11] = '{ADDAI, ADDCI, SUBBAI, ANLAI, ORLA, XRLA,
                             INCA, DECA, CPLA, CLRA, MOVAI};

   `include "tb_model.svh"

   core_top dut0 (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .o_code_addr (code_addr),
      .i_code_data (code_rdata),
      .o_reg_addr  (reg_addr),
      .o_reg_wr    (reg_wr),
      .o_reg_wdata (reg_wdata),
      .i_reg_rdata (reg_rdata),
      .o_uart_tx   (uart_line)
   );

   always #4 i_clk = ~i_clk;

   ////////////////////
   // memory models

   always @(negedge i_clk) begin
      addr_q  = code_addr;
      wr_pend = reg_wr;
      wr_rn   = reg_addr;
      wr_val  = reg_wdata;
   end

   always @(posedge i_clk) begin
      #1 code_rdata = code_mem[addr_q];  // one cycle read
      if (wr_pend) regs[wr_rn] = wr_val;
   end

   assign reg_rdata = regs[reg_addr];

   ////////////////////
   // program assembly

   task automatic emit(input byte_t v);
      code_mem[wp] = v;
      wp++;
   endtask

   task automatic expect_reg(input rn_t rn, input byte_t v);
      exp_rn_q.push_back(rn);
      exp_val_q.push_back(v);
   endtask

   // save acc in r7, poll busy, restore, write to the uart
   task automatic emit_send(input byte_t acc_exp);
      emit(op_rn(MOVRA, 3'd7));
      expect_reg(3'd7, acc_exp);
      emit(MOVDP);
      emit(XADDR_STAT[15:8]);
      emit(XADDR_STAT[7:0]);
      emit(MOVXAD);
      emit(JNZ);
      emit(8'hFD);  // back to movx
      emit(MOVDP);
      emit(XADDR_TX[15:8]);
      emit(XADDR_TX[7:0]);
      emit(op_rn(MOVAR, 3'd7));
      emit(MOVXDA);
      exp_byte_q.push_back(acc_exp);
   endtask

   task automatic begin_prog();
      for (int i = 0; i < (1 << CODE_AW); i++) code_mem[i] = 8'h00;
      for (int i = 0; i < 8; i++) regs[i] = 8'h00;
      wp = 0;
   endtask

   task automatic run_prog(input string name);
      int cnt;
      emit(SJMP);
      emit(8'hFE);  // park
      @(posedge i_clk);
      #1 i_nrst = 1'b0;
      repeat (15) @(posedge i_clk);
      @(negedge i_clk);
      compare_bit("o_uart_tx after reset", uart_line, 1'b1);
      @(posedge i_clk);
      #1 i_nrst = 1'b1;
      cnt = 0;
      while ((exp_byte_q.size() > 0) || (exp_rn_q.size() > 0)) begin
         @(negedge i_clk);
         cnt++;
         if (cnt > RUN_LIMIT) fail_stop({"program did not finish: ", name});
      end
   endtask

   ////////////////////
   // uart receiver and scoreboard

   initial begin : uart_rx
      int    idle;
      byte_t data;
      forever begin
         idle = 0;
         while (uart_line !== 1'b0) begin
            @(negedge i_clk);
            if (exp_byte_q.size() > 0) idle++;
            if (idle > RX_LIMIT) fail_stop("no frame started on o_uart_tx");
         end
         repeat ((BAUD_DIV + 1) / 2) @(negedge i_clk);  // middle of start bit
         compare_bit("o_uart_tx start bit", uart_line, 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV + 1) @(negedge i_clk);
            data[i] = uart_line;
         end
         repeat (BAUD_DIV + 1) @(negedge i_clk);
         compare_bit("o_uart_tx stop bit", uart_line, 1'b1);
         rx_q.push_back(data);
      end
   end

   initial begin : scoreboard
      forever begin
         @(negedge i_clk);
         if (rx_q.size() > 0) begin
            if (exp_byte_q.size() == 0) fail_stop("uart sent a byte that was not expected");
            compare_byte("uart byte", rx_q.pop_front(), exp_byte_q.pop_front());
         end
         if (reg_wr === 1'b1) begin
            if (exp_rn_q.size() == 0) fail_stop("register write that was not expected");
            compare_reg(reg_addr, exp_rn_q.pop_front(), reg_wdata, exp_val_q.pop_front());
         end
      end
   end

   ////////////////////
   // tests

   initial begin : main
      opcode_e     op;
      byte_t       a;
      byte_t       x;
      byte_t       v;
      byte_t       bb;
      logic        cy;
      rn_t         rn;
      logic [15:0] r;
      i_clk      = 1'b0;
      i_nrst     = 1'b0;
      code_rdata = 8'h00;
      void'($urandom(32'h1c83));

      // accumulator alu in two programs of twenty
      for (int p = 0; p < 2; p++) begin
         begin_prog();
         for (int i = 0; i < 20; i++) begin
            op = alu_ops[$urandom % 11];
            a  = byte_t'($urandom);
            x  = byte_t'($urandom);
            cy = 1'b0;
            if ((op == ADDCI) || (op == SUBBAI)) begin
               cy = $urandom % 2;
               emit(cy ? SETBC : CLRC);
            end
            emit(MOVAI);
            emit(a);
            emit(op);
            if (has_imm(op)) emit(x);
            r = ref_result(op, a, x, 8'h00, 8'h00, cy);
            emit_send(r[15:8]);
         end
         run_prog("alu");
      end

      // register file
      begin_prog();
      for (int i = 0; i < 6; i++) begin
         rn = $urandom % 7;  // r7 holds the send copy
         v  = byte_t'($urandom);
         a  = byte_t'($urandom);
         x  = byte_t'($urandom);
         emit(op_rn(MOVRI, rn));
         emit(v);
         r = ref_result(MOVRI, 8'h00, v, 8'h00, 8'h00, 1'b0);
         expect_reg(rn, r[7:0]);
         emit(op_rn(INCR, rn));
         r = ref_result(INCR, 8'h00, 8'h00, r[7:0], 8'h00, 1'b0);
         expect_reg(rn, r[7:0]);
         emit(op_rn(DECR, rn));
         r = ref_result(DECR, 8'h00, 8'h00, r[7:0], 8'h00, 1'b0);
         expect_reg(rn, r[7:0]);
         emit(op_rn(MOVAR, rn));
         r = ref_result(MOVAR, 8'h00, 8'h00, r[7:0], 8'h00, 1'b0);
         emit_send(r[15:8]);
         emit(MOVAI);
         emit(a);
         emit(op_rn(MOVRA, rn));
         r = ref_result(MOVRA, a, 8'h00, 8'h00, 8'h00, 1'b0);
         expect_reg(rn, r[7:0]);
         emit(MOVAI);
         emit(x);
         emit(op_rn(ADDAR, rn));
         r = ref_result(ADDAR, x, 8'h00, a, 8'h00, 1'b0);
         emit_send(r[15:8]);
      end
      run_prog("register file");

      // branches send marker a5 when taken and 5a when not
      begin_prog();
      for (int i = 0; i < 12; i++) begin
         op = (i % 4 == 0) ? JZ : (i % 4 == 1) ? JNZ : (i % 4 == 2) ? JC : JNC;
         a  = ($urandom % 3 == 0) ? 8'h00 : byte_t'($urandom);
         cy = $urandom % 2;
         emit(cy ? SETBC : CLRC);
         emit(MOVAI);
         emit(a);
         emit(op);
         emit(8'h04);
         emit(MOVAI);
         emit(8'h5A);
         emit(SJMP);
         emit(8'h02);
         emit(MOVAI);
         emit(8'hA5);
         emit_send(branch_taken(op, a, cy) ? 8'hA5 : 8'h5A);
      end
      run_prog("branches");

      // djnz loop counting up the accumulator
      for (int i = 0; i < 3; i++) begin
         begin_prog();
         v = 8'd1 + ($urandom % 30);
         emit(CLRA);
         emit(op_rn(MOVRI, 3'd0));
         emit(v);
         expect_reg(3'd0, v);
         emit(INCA);
         emit(op_rn(DJNZR, 3'd0));
         emit(8'hFD);  // back to inca
         for (int k = v - 1; k >= 0; k--) expect_reg(3'd0, byte_t'(k));
         emit_send(v);
         run_prog("djnz");
         compare_byte("r0 after djnz", regs[0], 8'h00);
      end

      // mul and div send the low byte or quotient first
      begin_prog();
      for (int i = 0; i < 8; i++) begin
         op = (i % 2 == 0) ? MUL : DIV;
         a  = byte_t'($urandom);
         bb = byte_t'($urandom);
         if ((op == DIV) && (bb == 8'h00)) bb = 8'h01;
         emit(MOVAI);
         emit(a);
         emit(MOVDI);
         emit(DIR_B);
         emit(bb);
         emit(op);
         r = ref_result(op, a, 8'h00, 8'h00, bb, 1'b0);
         emit_send(r[15:8]);
         emit(MOVAD);
         emit(DIR_B);
         emit_send(r[7:0]);
      end
      run_prog("mul div");

      // back to back sends
      begin_prog();
      for (int i = 0; i < 3; i++) begin
         x = byte_t'($urandom);
         emit(MOVAI);
         emit(x);
         emit_send(x);
      end
      run_prog("uart frames");

      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
hw/core_pkg.sv
hw/dec_exe_if.sv
hw/core_decode.sv
hw/core_execute.sv
hw/uart_tx.sv
hw/core_top.sv
bench/tb_core.sv
+incdir+bench
